//--- Makefile
# Verilator build for the zxuno i/o register testbench

VERILATOR ?= verilator
TOP       ?= zxuno_io_tb
FLIST     ?= zxuno_io_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "TB FAILED" $(LOG); then \
		echo "failure found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/zxuno_io_tb_ref.svh
`ifndef ZXUNO_IO_TB_REF_SVH
`define ZXUNO_IO_TB_REF_SVH

// --------------------
// shadow of written bytes
// --------------------

// last byte the cpu wrote to each register
typedef struct packed {
   logic [7:0] scndbl;
   logic [7:0] devopt;
   logic [7:0] rline_lo;
   logic [7:0] rctrl;
} shadow_t;

// expected {oe_n, data} of a data-port read
function automatic logic [8:0] exp_read(input logic [7:0] reg_num, input shadow_t sh,
                                        input logic rip);
   case (reg_num)
      `REG_SCANDBLCTRL: return {1'b0, sh.scndbl};
      `REG_DEVOPTIONS:  return {1'b0, sh.devopt};
      `REG_RASTERLINE:  return {1'b0, sh.rline_lo};
      // live status on top, three stored bits below
      `REG_RASTERCTRL:  return {1'b0, rip, 4'b0000, sh.rctrl[2:0]};
      default:          return {1'b1, 8'hFF};
   endcase
endfunction

// character at a string position, 00 past the end
function automatic logic [7:0] exp_coreid(input logic [3:0] index);
   logic [8*`COREID_LEN-1:0] text;
   int                       pos;
   text = `COREID_STRING;
   if (int'(index) >= `COREID_LEN) begin
      return 8'h00;
   end
   // first character sits in the top byte
   pos = 8 * (`COREID_LEN - 1 - int'(index));
   return text[pos +: 8];
endfunction

// {bdir, bc1} for one bus state
function automatic logic [1:0] exp_ay(input logic [15:0] addr, input logic iorq_n,
                                      input logic wr_n);
   logic port_hit;
   port_hit = addr[15] && (addr[1:0] == 2'b01) && !iorq_n;
   return {port_hit && !wr_n, port_hit && addr[14]};
endfunction

`endif

//--- dv/zxuno_io_tb.sv
`timescale 1ns/1ps
`include "zxuno_io_config.svh"

module zxuno_io_tb;
   import zxuno_io_pkg::*;
   `include "zxuno_io_tb_ref.svh"

   localparam int DRIVE_DLY = 1;
   // reset check, address port, two random loops of 16, core id, ay decode
   localparam int NUM_OPS = 9 + 83 + 16 * 9 * 2 + 15 + 33;
   localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + 100;
   localparam cpu_io_t CPU_IDLE = '{addr: 16'h0000, iorq_n: 1'b1, rd_n: 1'b1,
                                    wr_n: 1'b1, dout: 8'h00};

   logic         sysclk;
   logic         rst_n;
   logic         kbd_rst_n;
   logic         kbd_mrst_n;
   cpu_io_t      cpu;
   logic         raster_int_in_progress;
   byte_t        cpu_din;
   logic         cpu_oe_n;
   logic         bdir;
   logic         bc1;
   logic         vga_enable;
   logic         scanlines_enable;
   logic [2:0]   freq_option;
   logic [1:0]   turbo_option;
   logic         csync_option;
   logic         disable_ay;
   logic         disable_turboay;
   logic         disable_specdrum;
   logic         disable_mixer;
   logic         rasterint_enable;
   logic         vretraceint_disable;
   raster_line_t raster_line;

   // pending checks, filled by stimulus, drained by the compare process
   string        name_q[$];
   logic [15:0]  exp_q[$];
   logic [15:0]  act_q[$];
   int           errors = 0;
   int           checks = 0;

   zxuno_io_core uut (.*);

   initial begin
      sysclk = 1'b0;
      forever begin
         #5 sysclk = ~sysclk;
      end
   end

   // --------------------
   // bus tasks
   // --------------------

   task automatic io_write(input logic [15:0] addr, input byte_t data);
      @(posedge sysclk);
      #DRIVE_DLY;
      cpu = '{addr: addr, iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0, dout: data};
      repeat (2) @(posedge sysclk);
      #DRIVE_DLY;
      cpu = CPU_IDLE;
   endtask

   // strobe for two edges, sampled mid cycle
   task automatic io_read(input logic [15:0] addr, output byte_t data, output logic oe_n);
      @(posedge sysclk);
      #DRIVE_DLY;
      cpu = '{addr: addr, iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1, dout: 8'h00};
      @(posedge sysclk);
      @(negedge sysclk);
      data = cpu_din;
      oe_n = cpu_oe_n;
      @(posedge sysclk);
      #DRIVE_DLY;
      cpu = CPU_IDLE;
   endtask

   task automatic set_reg(input reg_addr_t num, input byte_t data);
      io_write(`ZXUNO_ADDR_PORT, num);
      io_write(`ZXUNO_DATA_PORT, data);
   endtask

   task automatic push_check(input string name, input logic [15:0] exp, input logic [15:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   // select a register, read it and queue both checks
   task automatic verify_reg(input reg_addr_t num, input shadow_t sh);
      byte_t      data;
      logic       oe_n;
      logic [8:0] exp;
      io_write(`ZXUNO_ADDR_PORT, num);
      io_read(`ZXUNO_DATA_PORT, data, oe_n);
      exp = exp_read(num, sh, raster_int_in_progress);
      push_check("cpu_din", 16'(exp[7:0]), 16'(data));
      push_check("cpu_oe_n", 16'(exp[8]), 16'(oe_n));
   endtask

   // decoded outputs against the bit maps
   task automatic compare_outputs(input shadow_t sh);
      @(negedge sysclk);
      push_check("vga_enable", 16'(sh.scndbl[0]), 16'(vga_enable));
      push_check("scanlines_enable", 16'(sh.scndbl[1]), 16'(scanlines_enable));
      push_check("freq_option", 16'(sh.scndbl[4:2]), 16'(freq_option));
      push_check("csync_option", 16'(sh.scndbl[5]), 16'(csync_option));
      push_check("turbo_option", 16'(sh.scndbl[7:6]), 16'(turbo_option));
      push_check("disable_ay", 16'(sh.devopt[0]), 16'(disable_ay));
      push_check("disable_turboay", 16'(sh.devopt[1]), 16'(disable_turboay));
      push_check("disable_specdrum", 16'(sh.devopt[6]), 16'(disable_specdrum));
      push_check("disable_mixer", 16'(sh.devopt[7]), 16'(disable_mixer));
      push_check("raster_line", 16'({sh.rctrl[0], sh.rline_lo}), 16'(raster_line));
      push_check("rasterint_enable", 16'(sh.rctrl[1]), 16'(rasterint_enable));
      push_check("vretraceint_disable", 16'(sh.rctrl[2]), 16'(vretraceint_disable));
   endtask

   // --------------------
   // compare process
   // --------------------
   initial begin : compare
      string       name;
      logic [15:0] exp;
      logic [15:0] act;
      forever begin
         @(posedge sysclk);
         while (act_q.size() > 0) begin
            name = name_q.pop_front();
            exp = exp_q.pop_front();
            act = act_q.pop_front();
            checks++;
            if (exp !== act) begin
               errors++;
               $display("Mismatch %s: expected %0h, got %0h", name, exp, act);
            end
         end
      end
   end

   // --------------------
   // stimulus
   // --------------------
   initial begin : stimulus
      shadow_t     sh;
      byte_t       data;
      byte_t       num;
      logic        oe_n;
      logic [15:0] addr;
      logic        iorq_n_v;
      logic        wr_n_v;
      logic [1:0]  ay;
      void'($urandom(32'h9802_c372));
      cpu = CPU_IDLE;
      rst_n = 1'b0;
      kbd_rst_n = 1'b1;
      kbd_mrst_n = 1'b1;
      raster_int_in_progress = 1'b0;
      repeat (5) @(posedge sysclk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      // reset values, 0b to 0e
      sh = '{scndbl: 8'h00, devopt: 8'h00, rline_lo: 8'hFF, rctrl: 8'h00};
      compare_outputs(sh);
      for (int i = 0; i < 4; i++) begin
         verify_reg(`REG_SCANDBLCTRL + 8'(i), sh);
      end

      // address port readback
      for (int i = 0; i < 40; i++) begin
         num = 8'($urandom());
         io_write(`ZXUNO_ADDR_PORT, num);
         io_read(`ZXUNO_ADDR_PORT, data, oe_n);
         push_check("cpu_din", 16'(num), 16'(data));
         push_check("cpu_oe_n", 16'h0000, 16'(oe_n));
      end
      // nothing decodes these, bus floats high
      io_read(16'h1234, data, oe_n);
      push_check("cpu_din", 16'h00FF, 16'(data));
      push_check("cpu_oe_n", 16'h0001, 16'(oe_n));
      verify_reg(8'h42, sh);

      // scandoubler and device options
      for (int i = 0; i < 16; i++) begin
         sh.scndbl = 8'($urandom());
         sh.devopt = 8'($urandom());
         set_reg(`REG_SCANDBLCTRL, sh.scndbl);
         set_reg(`REG_DEVOPTIONS, sh.devopt);
         verify_reg(`REG_SCANDBLCTRL, sh);
         verify_reg(`REG_DEVOPTIONS, sh);
         compare_outputs(sh);
      end

      // raster line and control, status bit flips each pass
      for (int i = 0; i < 16; i++) begin
         sh.rline_lo = 8'($urandom());
         sh.rctrl = 8'($urandom());
         set_reg(`REG_RASTERLINE, sh.rline_lo);
         set_reg(`REG_RASTERCTRL, sh.rctrl);
         raster_int_in_progress = ~raster_int_in_progress;
         verify_reg(`REG_RASTERLINE, sh);
         verify_reg(`REG_RASTERCTRL, sh);
         compare_outputs(sh);
      end

      // core id string, terminator, wrap
      io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
      for (int k = 0; k < 12; k++) begin
         io_read(`ZXUNO_DATA_PORT, data, oe_n);
         push_check("coreid", 16'(exp_coreid(4'(k % (`COREID_LEN + 1)))), 16'(data));
         push_check("cpu_oe_n", 16'h0000, 16'(oe_n));
      end
      // address rewrite restarts at the first character
      io_write(`ZXUNO_ADDR_PORT, `REG_COREID);
      io_read(`ZXUNO_DATA_PORT, data, oe_n);
      push_check("coreid", 16'(exp_coreid(4'd0)), 16'(data));

      // ay decode, half the addresses on the ay port pattern
      for (int i = 0; i < 32; i++) begin
         addr = 16'($urandom());
         if ($urandom() % 2 == 0) begin
            addr[1:0] = 2'b01;
         end
         iorq_n_v = 1'($urandom());
         wr_n_v = 1'($urandom());
         @(posedge sysclk);
         #DRIVE_DLY;
         cpu = '{addr: addr, iorq_n: iorq_n_v, rd_n: 1'b1, wr_n: wr_n_v, dout: 8'h00};
         @(negedge sysclk);
         ay = exp_ay(addr, iorq_n_v, wr_n_v);
         push_check("bdir", 16'(ay[1]), 16'(bdir));
         push_check("bc1", 16'(ay[0]), 16'(bc1));
      end
      @(posedge sysclk);
      #DRIVE_DLY;
      cpu = CPU_IDLE;

      // let the compare process drain
      repeat (2) @(posedge sysclk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // --------------------
   // watchdog
   // --------------------
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sysclk);
      $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- source/coreid.sv
`timescale 1ns/1ps
`include "zxuno_io_config.svh"

module coreid (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  zxuno_io_pkg::reg_bus_t regs,
   output zxuno_io_pkg::rd_path_t rd
);
   typedef enum logic {IDLE, READING} state_t;

   // string packed with the first character on top
   localparam logic [8*`COREID_LEN-1:0] ID_STR = `COREID_STRING;
   // terminator slot one past the last character
   localparam logic [3:0] TERM_IDX = 4'(`COREID_LEN);

   state_t     state;
   logic [3:0] index;
   logic [2:0] char_pos;
   logic       sel_id;

   assign sel_id = regs.regrd && (regs.addr == `REG_COREID);

   // --------------------
   // read fsm and index
   // --------------------

   // step once the read strobe drops
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         index <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (sel_id) begin
                  state <= READING;
               end
            end
            READING: begin
               if (!regs.regrd) begin
                  state <= IDLE;
                  index <= (index == TERM_IDX) ? 4'd0 : index + 4'd1;
               end
            end
            default: state <= IDLE;
         endcase
         // new address write restarts the string
         if (regs.regaddr_changed) begin
            index <= '0;
         end
      end
   end

   // byte position counted from the top of the string
   assign char_pos = 3'(TERM_IDX - 4'd1 - index);

   assign rd.data = (index == TERM_IDX) ? 8'h00 : ID_STR[{char_pos, 3'b000} +: 8];
   assign rd.oe_n = !sel_id;

   // never past the terminator
   a_idx_range : assert property (@(posedge sysclk) disable iff (!rst_n)
      index <= TERM_IDX);

endmodule

//--- source/option_regs.sv
`timescale 1ns/1ps
`include "zxuno_io_config.svh"

module option_regs (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  zxuno_io_pkg::cpu_io_t  cpu,
   input  zxuno_io_pkg::reg_bus_t regs,
   output zxuno_io_pkg::rd_path_t rd,
   output logic                   vga_enable,
   output logic                   scanlines_enable,
   output logic [2:0]             freq_option,
   output logic                   csync_option,
   output logic [1:0]             turbo_option,
   output logic                   disable_ay,
   output logic                   disable_turboay,
   output logic                   disable_specdrum,
   output logic                   disable_mixer
);
   import zxuno_io_pkg::*;

   byte_t scndbl_q;
   byte_t devopt_q;
   logic  sel_scndbl;
   logic  sel_devopt;

   // register select from the latched number
   assign sel_scndbl = (regs.addr == `REG_SCANDBLCTRL);
   assign sel_devopt = (regs.addr == `REG_DEVOPTIONS);

   // --------------------
   // register writes
   // --------------------

   // level write, same value each edge of the cycle
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         scndbl_q <= '0;
         devopt_q <= '0;
      end else if (regs.regwr) begin
         if (sel_scndbl) begin
            scndbl_q <= cpu.dout;
         end
         if (sel_devopt) begin
            devopt_q <= cpu.dout;
         end
      end
   end

   // --------------------
   // decoded outputs
   // --------------------

   // scandoubler byte
   assign vga_enable       = scndbl_q[0];
   assign scanlines_enable = scndbl_q[1];
   assign freq_option      = scndbl_q[4:2];
   assign csync_option     = scndbl_q[5];
   assign turbo_option     = scndbl_q[7:6];

   // device options, bits 5:2 only stored
   assign disable_ay       = devopt_q[0];
   assign disable_turboay  = devopt_q[1];
   assign disable_specdrum = devopt_q[6];
   assign disable_mixer    = devopt_q[7];

   // --------------------
   // read path
   // --------------------

   // whole bytes read back as written
   assign rd.data = sel_scndbl ? scndbl_q : devopt_q;
   assign rd.oe_n = !(regs.regrd && (sel_scndbl || sel_devopt));

endmodule

//--- source/rasterint_ctrl.sv
`timescale 1ns/1ps
`include "zxuno_io_config.svh"

module rasterint_ctrl (
   input  logic                       sysclk,
   input  logic                       rst_n,
   input  zxuno_io_pkg::cpu_io_t      cpu,
   input  zxuno_io_pkg::reg_bus_t     regs,
   input  logic                       raster_int_in_progress,
   output zxuno_io_pkg::rd_path_t     rd,
   output logic                       rasterint_enable,
   output logic                       vretraceint_disable,
   output zxuno_io_pkg::raster_line_t raster_line
);
   import zxuno_io_pkg::*;

   raster_line_t line_q;
   logic         int_en_q;
   logic         vr_dis_q;
   logic         sel_line;
   logic         sel_ctrl;
   byte_t        ctrl_rd;

   assign sel_line = (regs.addr == `REG_RASTERLINE);
   assign sel_ctrl = (regs.addr == `REG_RASTERCTRL);

   // --------------------
   // register writes
   // --------------------

   // 0c gives line bits 7:0, 0d gives bit 8 and the enables
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         line_q   <= `RASTERLINE_RESET;
         int_en_q <= 1'b0;
         vr_dis_q <= 1'b0;
      end else if (regs.regwr) begin
         if (sel_line) begin
            line_q[7:0] <= cpu.dout;
         end
         if (sel_ctrl) begin
            line_q[8] <= cpu.dout[0];
            int_en_q  <= cpu.dout[1];
            vr_dis_q  <= cpu.dout[2];
         end
      end
   end

   assign raster_line         = line_q;
   assign rasterint_enable    = int_en_q;
   assign vretraceint_disable = vr_dis_q;

   // live status in bit 7, unused bits zero
   assign ctrl_rd = {raster_int_in_progress, 4'b0000, vr_dis_q, int_en_q, line_q[8]};

   assign rd.data = sel_ctrl ? ctrl_rd : line_q[7:0];
   assign rd.oe_n = !(regs.regrd && (sel_line || sel_ctrl));

   // line only moves on a data port write
   a_line_hold : assert property (@(posedge sysclk) disable iff (!rst_n)
      !regs.regwr |=> $stable(raster_line));

endmodule

//--- source/zxuno_io_config.svh
`ifndef ZXUNO_IO_CONFIG_SVH
`define ZXUNO_IO_CONFIG_SVH

// --------------------
// z80 i/o ports
// --------------------

// register-address port, write selects, read returns latch
`define ZXUNO_ADDR_PORT 16'hFC3B
// register-data port, reaches the selected register
`define ZXUNO_DATA_PORT 16'hFD3B

// --------------------
// internal register numbers
// --------------------
`define REG_SCANDBLCTRL 8'h0B
`define REG_RASTERLINE  8'h0C
`define REG_RASTERCTRL  8'h0D
`define REG_DEVOPTIONS  8'h0E
`define REG_COREID      8'hFF

// --------------------
// reset and constant values
// --------------------

// full 9-bit raster line after reset
`define RASTERLINE_RESET 9'h0FF

// core id text, first character in the top byte
`define COREID_STRING "EXP-IO01"
`define COREID_LEN    8

`endif

//--- source/zxuno_io_core.sv
`timescale 1ns/1ps

module zxuno_io_core (
   input  logic                       sysclk,
   input  logic                       rst_n,
   input  logic                       kbd_rst_n,
   input  logic                       kbd_mrst_n,
   input  zxuno_io_pkg::cpu_io_t      cpu,
   input  logic                       raster_int_in_progress,
   output zxuno_io_pkg::byte_t        cpu_din,
   output logic                       cpu_oe_n,
   output logic                       bdir,
   output logic                       bc1,
   output logic                       vga_enable,
   output logic                       scanlines_enable,
   output logic [2:0]                 freq_option,
   output logic [1:0]                 turbo_option,
   output logic                       csync_option,
   output logic                       disable_ay,
   output logic                       disable_turboay,
   output logic                       disable_specdrum,
   output logic                       disable_mixer,
   output logic                       rasterint_enable,
   output logic                       vretraceint_disable,
   output zxuno_io_pkg::raster_line_t raster_line
);
   import zxuno_io_pkg::*;

   logic     sys_rst_n;
   reg_bus_t regs;
   rd_path_t rd_addr;
   rd_path_t rd_opt;
   rd_path_t rd_rast;
   rd_path_t rd_id;

   // any of the three sources resets the block
   assign sys_rst_n = rst_n & kbd_rst_n & kbd_mrst_n;

   // --------------------
   // ay-3-8912 decode
   // --------------------

   // bdir/bc1: 11 address, 10 write, 01 read
   assign bdir = cpu.addr[15] && (cpu.addr[1:0] == 2'b01) && !cpu.iorq_n && !cpu.wr_n;
   assign bc1  = cpu.addr[15] && cpu.addr[14] && (cpu.addr[1:0] == 2'b01) && !cpu.iorq_n;

   // --------------------
   // register blocks
   // --------------------
   zxuno_regaddr u_regaddr (
      .sysclk (sysclk),
      .rst_n  (sys_rst_n),
      .cpu    (cpu),
      .regs   (regs),
      .rd     (rd_addr)
   );

   option_regs u_option_regs (
      .sysclk           (sysclk),
      .rst_n            (sys_rst_n),
      .cpu              (cpu),
      .regs             (regs),
      .rd               (rd_opt),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .freq_option      (freq_option),
      .csync_option     (csync_option),
      .turbo_option     (turbo_option),
      .disable_ay       (disable_ay),
      .disable_turboay  (disable_turboay),
      .disable_specdrum (disable_specdrum),
      .disable_mixer    (disable_mixer)
   );

   rasterint_ctrl u_rasterint_ctrl (
      .sysclk                 (sysclk),
      .rst_n                  (sys_rst_n),
      .cpu                    (cpu),
      .regs                   (regs),
      .raster_int_in_progress (raster_int_in_progress),
      .rd                     (rd_rast),
      .rasterint_enable       (rasterint_enable),
      .vretraceint_disable    (vretraceint_disable),
      .raster_line            (raster_line)
   );

   coreid u_coreid (
      .sysclk (sysclk),
      .rst_n  (sys_rst_n),
      .regs   (regs),
      .rd     (rd_id)
   );

   // --------------------
   // cpu data-in mux
   // --------------------

   // fixed priority, idle bus floats high
   always_comb begin
      if (!rd_addr.oe_n) begin
         cpu_din = rd_addr.data;
      end else if (!rd_opt.oe_n) begin
         cpu_din = rd_opt.data;
      end else if (!rd_rast.oe_n) begin
         cpu_din = rd_rast.data;
      end else if (!rd_id.oe_n) begin
         cpu_din = rd_id.data;
      end else begin
         cpu_din = 8'hFF;
      end
   end

   assign cpu_oe_n = rd_addr.oe_n & rd_opt.oe_n & rd_rast.oe_n & rd_id.oe_n;

endmodule

//--- source/zxuno_io_pkg.sv
package zxuno_io_pkg;

   // --------------------
   // plain vector types
   // --------------------

   // one data byte on the cpu bus
   typedef logic [7:0] byte_t;

   // number of an internal register
   typedef logic [7:0] reg_addr_t;

   // full z80 i/o address
   typedef logic [15:0] io_addr_t;

   // raster line compare value
   typedef logic [8:0] raster_line_t;

   // --------------------
   // bus structs
   // --------------------

   // z80 side of an i/o access, strobes active low
   typedef struct packed {
      io_addr_t addr;
      logic     iorq_n;
      logic     rd_n;
      logic     wr_n;
      byte_t    dout;
   } cpu_io_t;

   // register bus shared by all register blocks
   typedef struct packed {
      reg_addr_t addr;
      logic      regrd;
      logic      regwr;
      logic      regaddr_changed;
   } reg_bus_t;

   // read path back to the cpu mux
   typedef struct packed {
      byte_t data;
      logic  oe_n;
   } rd_path_t;

endpackage

//--- source/zxuno_regaddr.sv
`timescale 1ns/1ps
`include "zxuno_io_config.svh"

module zxuno_regaddr (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  zxuno_io_pkg::cpu_io_t  cpu,
   output zxuno_io_pkg::reg_bus_t regs,
   output zxuno_io_pkg::rd_path_t rd
);
   import zxuno_io_pkg::*;

   reg_addr_t addr_q;
   logic      addr_wr;
   logic      addr_wr_q;
   logic      addr_rd;
   logic      chg_q;

   // --------------------
   // port decode
   // --------------------

   // access to fc3b, write or read
   assign addr_wr = !cpu.iorq_n && !cpu.wr_n && (cpu.addr == `ZXUNO_ADDR_PORT);
   assign addr_rd = !cpu.iorq_n && !cpu.rd_n && (cpu.addr == `ZXUNO_ADDR_PORT);

   // data port strobes are plain levels
   assign regs.regrd = !cpu.iorq_n && !cpu.rd_n && (cpu.addr == `ZXUNO_DATA_PORT);
   assign regs.regwr = !cpu.iorq_n && !cpu.wr_n && (cpu.addr == `ZXUNO_DATA_PORT);

   // --------------------
   // address latch
   // --------------------

   // rewritten on every edge of the bus cycle
   // changed flag only on the first one
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q    <= '0;
         addr_wr_q <= 1'b0;
         chg_q     <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         chg_q     <= addr_wr && !addr_wr_q;
         if (addr_wr) begin
            addr_q <= cpu.dout;
         end
      end
   end

   assign regs.addr            = addr_q;
   assign regs.regaddr_changed = chg_q;

   // readback of the selected register number
   assign rd.data = addr_q;
   assign rd.oe_n = !addr_rd;

   // a z80 cycle is either a read or a write, never both
   a_no_rd_wr : assert property (@(posedge sysclk) disable iff (!rst_n)
      !(regs.regrd && regs.regwr));

endmodule

//--- zxuno_io_core.f
+incdir+source
+incdir+dv
source/zxuno_io_pkg.sv
source/zxuno_regaddr.sv
source/option_regs.sv
source/rasterint_ctrl.sv
source/coreid.sv
source/zxuno_io_core.sv
dv/zxuno_io_tb.sv
